// ==== include/sauria_params.svh ====
// SAURIA configuration subsystem parameters
// Bus widths, scratchpad geometry, address region codes,
// register indices and the unmapped-address read word

`ifndef SAURIA_PARAMS_SVH
`define SAURIA_PARAMS_SVH

// Configuration bus
`define SAURIA_ADDR_W   32
`define SAURIA_DATA_W   32

// Scratchpad geometry
`define SCRATCH_DEPTH   64
`define SCRATCH_IDX_W   6
// Copy length of 0 to 64 words
`define COUNT_W         7

// Address bits 15:12 select the region
`define REGION_REGS     4'h0
`define REGION_MEM      4'h1

// Register indices from address bits 4:2
`define REG_CTRL        3'd0
`define REG_STATUS      3'd1
`define REG_SRC         3'd2
`define REG_DST         3'd3
`define REG_LEN         3'd4

// Read data returned for unmapped addresses
`define BAD_ADDR_WORD   32'h0BADADD2

`endif

// ==== verilog/sauria_pkg.sv ====
// SAURIA configuration subsystem types
// Vector typedefs for addresses, data words, scratchpad indices
// and copy lengths, plus the dataflow controller state encoding

`default_nettype none

`include "sauria_params.svh"

package sauria_pkg;

    // ------------------------------------------------------------
    // Bus and data
    // ------------------------------------------------------------
    typedef logic [`SAURIA_ADDR_W-1:0]  cfg_addr_t;
    typedef logic [`SAURIA_DATA_W-1:0]  cfg_data_t;

    // ------------------------------------------------------------
    // Scratchpad and copy descriptor
    // ------------------------------------------------------------
    typedef logic [`SCRATCH_IDX_W-1:0]  mem_idx_t;
    typedef logic [`COUNT_W-1:0]        word_count_t;

    // Register index within the register region
    typedef logic [2:0]                 reg_idx_t;

    // Dataflow controller states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cfg_bus_decoder.sv ====
// Configuration bus decoder
// Wishbone classic slave. Accepts one request at a time, decodes the
// region from address bits 15:12 and forwards the access to the
// register block or the scratchpad. Unmapped addresses get err with
// a fixed read word. The response comes one cycle after acceptance.

`timescale 1ns/10ps
`default_nettype none

`include "sauria_params.svh"

module cfg_bus_decoder
    import sauria_pkg::*;
(
    input  logic        i_system_clk,
    input  logic        i_arst_n,

    // Wishbone slave
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  cfg_addr_t   i_wb_adr,
    input  cfg_data_t   i_wb_dat,
    output cfg_data_t   o_wb_dat,
    output logic        o_wb_ack,
    output logic        o_wb_err,

    // Register block
    output logic        o_reg_we,
    output reg_idx_t    o_reg_idx,
    output cfg_data_t   o_reg_wdat,
    input  cfg_data_t   i_reg_rdat,

    // Scratchpad debug port
    output logic        o_mem_en,
    output logic        o_mem_we,
    output mem_idx_t    o_mem_idx,
    output cfg_data_t   o_mem_wdat,
    input  cfg_data_t   i_mem_rdat
);

    logic       accept;
    logic [3:0] region;
    logic       reg_hit;
    logic       mem_hit;
    logic       sel_mem_q;
    cfg_data_t  rdat_q;

    // ------------------------------------------------------------
    // Acceptance and region decode
    // ------------------------------------------------------------
    // No new request while the response is on the bus
    assign accept  = i_wb_cyc && i_wb_stb && !(o_wb_ack || o_wb_err);
    assign region  = i_wb_adr[15:12];
    assign reg_hit = accept && (region == `REGION_REGS);
    assign mem_hit = accept && (region == `REGION_MEM);

    // Writes take effect in the accept cycle
    assign o_reg_we   = reg_hit && i_wb_we;
    assign o_reg_idx  = i_wb_adr[4:2];
    assign o_reg_wdat = i_wb_dat;

    assign o_mem_en   = mem_hit;
    assign o_mem_we   = mem_hit && i_wb_we;
    assign o_mem_idx  = i_wb_adr[`SCRATCH_IDX_W+1:2];
    assign o_mem_wdat = i_wb_dat;

    // ------------------------------------------------------------
    // Response
    // ------------------------------------------------------------
    always_ff @(posedge i_system_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_ack  <= 1'b0;
            o_wb_err  <= 1'b0;
            sel_mem_q <= 1'b0;
        end else begin
            o_wb_ack  <= reg_hit || mem_hit;
            o_wb_err  <= accept && !reg_hit && !mem_hit;
            sel_mem_q <= mem_hit;
        end
    end

    // Register data or the error word, captured at acceptance
    always_ff @(posedge i_system_clk) begin
        if (accept) begin
            rdat_q <= reg_hit ? i_reg_rdat : `BAD_ADDR_WORD;
        end
    end

    // Scratchpad data is already registered inside the memory
    assign o_wb_dat = sel_mem_q ? i_mem_rdat : rdat_q;

    // Every response belongs to a request accepted one cycle earlier
    a_one_response: assert property (
        @(posedge i_system_clk) disable iff (!i_arst_n)
        (o_wb_ack || o_wb_err) |-> !(o_wb_ack && o_wb_err) && $past(accept)
    );

endmodule

`default_nettype wire

// ==== verilog/ctrl_regfile.sv ====
// Control register block
// CTRL (start trigger, interrupt enable), STATUS (busy, sticky done),
// and the SRC, DST and LEN copy descriptor. Raises the start pulse
// for the controller and the completion interrupt.

`timescale 1ns/10ps
`default_nettype none

`include "sauria_params.svh"

module ctrl_regfile
    import sauria_pkg::*;
(
    input  logic        i_system_clk,
    input  logic        i_arst_n,

    input  logic        i_reg_we,
    input  reg_idx_t    i_reg_idx,
    input  cfg_data_t   i_reg_wdat,
    output cfg_data_t   o_reg_rdat,

    input  logic        i_busy,
    input  logic        i_done,
    output logic        o_start,
    output mem_idx_t    o_src,
    output mem_idx_t    o_dst,
    output word_count_t o_len,
    output logic        o_intr
);

    logic        intr_en_q;
    logic        done_flag_q;
    mem_idx_t    src_q;
    mem_idx_t    dst_q;
    word_count_t len_q;

    // ------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------
    always_ff @(posedge i_system_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            intr_en_q   <= 1'b0;
            done_flag_q <= 1'b0;
            src_q       <= '0;
            dst_q       <= '0;
            len_q       <= '0;
            o_start     <= 1'b0;
        end else begin
            // Start only when the controller is free
            o_start <= i_reg_we && (i_reg_idx == `REG_CTRL) && i_reg_wdat[0]
                       && !i_busy && !o_start;

            if (i_reg_we) begin
                case (i_reg_idx)
                    `REG_CTRL:   intr_en_q <= i_reg_wdat[1];
                    `REG_SRC:    src_q     <= i_reg_wdat[`SCRATCH_IDX_W-1:0];
                    `REG_DST:    dst_q     <= i_reg_wdat[`SCRATCH_IDX_W-1:0];
                    `REG_LEN: begin
                        // Saturate at the scratchpad size
                        if (i_reg_wdat > `SCRATCH_DEPTH) begin
                            len_q <= word_count_t'(`SCRATCH_DEPTH);
                        end else begin
                            len_q <= i_reg_wdat[`COUNT_W-1:0];
                        end
                    end
                    default: ;
                endcase
            end

            // Set wins over a write-one clear in the same cycle
            if (i_done) begin
                done_flag_q <= 1'b1;
            end else if (i_reg_we && (i_reg_idx == `REG_STATUS) && i_reg_wdat[1]) begin
                done_flag_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        o_reg_rdat = '0;
        case (i_reg_idx)
            `REG_CTRL:   o_reg_rdat[1]   = intr_en_q;
            `REG_STATUS: o_reg_rdat[1:0] = {done_flag_q, i_busy};
            `REG_SRC:    o_reg_rdat      = cfg_data_t'(src_q);
            `REG_DST:    o_reg_rdat      = cfg_data_t'(dst_q);
            `REG_LEN:    o_reg_rdat      = cfg_data_t'(len_q);
            default:     o_reg_rdat      = '0;
        endcase
    end

    assign o_src  = src_q;
    assign o_dst  = dst_q;
    assign o_len  = len_q;
    assign o_intr = done_flag_q && intr_en_q;

    // Controller must never see a start while it is running
    a_start_idle: assert property (
        @(posedge i_system_clk) disable iff (!i_arst_n)
        o_start |-> !i_busy
    );

endmodule

`default_nettype wire

// ==== verilog/df_control_fsm.sv ====
// Dataflow controller
// Sequences a scratchpad copy: one READ and one WRITE cycle per
// word, then a one-cycle DONE. Zero length goes straight to DONE.

`timescale 1ns/10ps
`default_nettype none

module df_control_fsm
    import sauria_pkg::*;
(
    input  logic        i_system_clk,
    input  logic        i_arst_n,

    input  logic        i_start,
    input  word_count_t i_len,
    input  logic        i_last_word,

    output logic        o_load,
    output logic        o_step,
    output logic        o_rd_en,
    output logic        o_wr_en,
    output logic        o_busy,
    output logic        o_done
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_start) begin
                    state_d = (i_len == '0) ? DONE : READ;
                end
            end
            READ:  state_d = WRITE;
            WRITE: state_d = i_last_word ? DONE : READ;
            DONE:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_system_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counter picks up the descriptor with the start
    assign o_load  = (state_q == IDLE) && i_start;
    // Read data is on port B in the following WRITE cycle
    assign o_rd_en = (state_q == READ);
    assign o_wr_en = (state_q == WRITE);
    assign o_step  = (state_q == WRITE);
    assign o_busy  = (state_q != IDLE);
    assign o_done  = (state_q == DONE);

    // Counter holds the new length one cycle after the load
    a_load_count: assert property (
        @(posedge i_system_clk) disable iff (!i_arst_n)
        o_load |=> (i_last_word == ($past(i_len) == word_count_t'(1)))
    );

endmodule

`default_nettype wire

// ==== verilog/dma_word_counter.sv ====
// DMA word counter
// Source and destination pointers and the remaining word count.
// Pointers wrap around the scratchpad.

`timescale 1ns/10ps
`default_nettype none

module dma_word_counter
    import sauria_pkg::*;
(
    input  logic        i_system_clk,
    input  logic        i_arst_n,

    input  logic        i_load,
    input  logic        i_step,
    input  mem_idx_t    i_src,
    input  mem_idx_t    i_dst,
    input  word_count_t i_len,

    output mem_idx_t    o_src_ptr,
    output mem_idx_t    o_dst_ptr,
    output logic        o_last_word
);

    word_count_t remain_q;

    always_ff @(posedge i_system_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_src_ptr <= '0;
            o_dst_ptr <= '0;
            remain_q  <= '0;
        end else if (i_load) begin
            o_src_ptr <= i_src;
            o_dst_ptr <= i_dst;
            remain_q  <= i_len;
        end else if (i_step) begin
            // Natural 6-bit overflow gives the wrap at 64
            o_src_ptr <= o_src_ptr + 1'b1;
            o_dst_ptr <= o_dst_ptr + 1'b1;
            remain_q  <= remain_q - 1'b1;
        end
    end

    assign o_last_word = (remain_q == word_count_t'(1));

endmodule

`default_nettype wire

// ==== verilog/scratch_mem.sv ====
// Scratchpad memory
// 64 x 32-bit words. Port A serves bus debug access, port B serves
// the DMA with separate read and write indices. Synchronous reads.

`timescale 1ns/10ps
`default_nettype none

`include "sauria_params.svh"

module scratch_mem
    import sauria_pkg::*;
(
    input  logic      i_system_clk,

    // Port A for bus debug
    input  logic      i_a_en,
    input  logic      i_a_we,
    input  mem_idx_t  i_a_idx,
    input  cfg_data_t i_a_wdat,
    output cfg_data_t o_a_rdat,

    // Port B for the DMA
    input  logic      i_b_rd_en,
    input  mem_idx_t  i_b_rd_idx,
    output cfg_data_t o_b_rdat,
    input  logic      i_b_wr_en,
    input  mem_idx_t  i_b_wr_idx,
    input  cfg_data_t i_b_wdat
);

    cfg_data_t mem [`SCRATCH_DEPTH];

    always_ff @(posedge i_system_clk) begin
        if (i_a_en) begin
            o_a_rdat <= mem[i_a_idx];
            if (i_a_we) begin
                mem[i_a_idx] <= i_a_wdat;
            end
        end
        if (i_b_rd_en) begin
            o_b_rdat <= mem[i_b_rd_idx];
        end
        // Last assignment wins, so port B has priority on a clash
        if (i_b_wr_en) begin
            mem[i_b_wr_idx] <= i_b_wdat;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sauria_subsystem.sv ====
// SAURIA configuration subsystem top level
// Wishbone configuration port decoded into the register block, the
// scratchpad debug port and an error responder. A dataflow controller
// runs a word copy inside the scratchpad and raises o_intr when done.

`timescale 1ns/10ps
`default_nettype none

module sauria_subsystem
    import sauria_pkg::*;
(
    input  logic      i_system_clk,
    input  logic      i_arst_n,

    // Configuration Wishbone slave
    input  logic      i_wb_cyc,
    input  logic      i_wb_stb,
    input  logic      i_wb_we,
    input  cfg_addr_t i_wb_adr,
    input  cfg_data_t i_wb_dat,
    output cfg_data_t o_wb_dat,
    output logic      o_wb_ack,
    output logic      o_wb_err,

    // Copy completion interrupt
    output logic      o_intr
);

    // ------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------
    logic        reg_we;
    reg_idx_t    reg_idx;
    cfg_data_t   reg_wdat;
    cfg_data_t   reg_rdat;

    logic        mem_en;
    logic        mem_we;
    mem_idx_t    mem_idx;
    cfg_data_t   mem_wdat;
    cfg_data_t   mem_rdat;

    logic        start;
    logic        busy;
    logic        done;
    mem_idx_t    src;
    mem_idx_t    dst;
    word_count_t len;

    logic        load;
    logic        step;
    logic        last_word;
    logic        dma_rd_en;
    logic        dma_wr_en;
    mem_idx_t    src_ptr;
    mem_idx_t    dst_ptr;
    cfg_data_t   dma_rdat;

    // ------------------------------------------------------------
    // Configuration path
    // ------------------------------------------------------------
    cfg_bus_decoder cfg_bus_decoder_i (
        .i_system_clk (i_system_clk),
        .i_arst_n     (i_arst_n),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_wb_err     (o_wb_err),
        .o_reg_we     (reg_we),
        .o_reg_idx    (reg_idx),
        .o_reg_wdat   (reg_wdat),
        .i_reg_rdat   (reg_rdat),
        .o_mem_en     (mem_en),
        .o_mem_we     (mem_we),
        .o_mem_idx    (mem_idx),
        .o_mem_wdat   (mem_wdat),
        .i_mem_rdat   (mem_rdat)
    );

    ctrl_regfile ctrl_regfile_i (
        .i_system_clk (i_system_clk),
        .i_arst_n     (i_arst_n),
        .i_reg_we     (reg_we),
        .i_reg_idx    (reg_idx),
        .i_reg_wdat   (reg_wdat),
        .o_reg_rdat   (reg_rdat),
        .i_busy       (busy),
        .i_done       (done),
        .o_start      (start),
        .o_src        (src),
        .o_dst        (dst),
        .o_len        (len),
        .o_intr       (o_intr)
    );

    // ------------------------------------------------------------
    // Copy engine
    // ------------------------------------------------------------
    df_control_fsm df_control_fsm_i (
        .i_system_clk (i_system_clk),
        .i_arst_n     (i_arst_n),
        .i_start      (start),
        .i_len        (len),
        .i_last_word  (last_word),
        .o_load       (load),
        .o_step       (step),
        .o_rd_en      (dma_rd_en),
        .o_wr_en      (dma_wr_en),
        .o_busy       (busy),
        .o_done       (done)
    );

    dma_word_counter dma_word_counter_i (
        .i_system_clk (i_system_clk),
        .i_arst_n     (i_arst_n),
        .i_load       (load),
        .i_step       (step),
        .i_src        (src),
        .i_dst        (dst),
        .i_len        (len),
        .o_src_ptr    (src_ptr),
        .o_dst_ptr    (dst_ptr),
        .o_last_word  (last_word)
    );

    // Port B read data loops straight back as its write data
    scratch_mem scratch_mem_i (
        .i_system_clk (i_system_clk),
        .i_a_en       (mem_en),
        .i_a_we       (mem_we),
        .i_a_idx      (mem_idx),
        .i_a_wdat     (mem_wdat),
        .o_a_rdat     (mem_rdat),
        .i_b_rd_en    (dma_rd_en),
        .i_b_rd_idx   (src_ptr),
        .o_b_rdat     (dma_rdat),
        .i_b_wr_en    (dma_wr_en),
        .i_b_wr_idx   (dst_ptr),
        .i_b_wdat     (dma_rdat)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_sauria_subsystem.sv ====
// Testbench for the SAURIA configuration subsystem
// Reads bus operations and expected values from the pattern file,
// drives them over Wishbone and checks responses, o_intr and the
// done flag. Prints one line per test and a closing count line.

`timescale 1ns/10ps
`default_nettype none

module tb_sauria_subsystem;

    localparam logic [31:0] STATUS_ADDR = 32'h0000_0004;
    localparam logic [31:0] ERR_WORD    = 32'h0BAD_ADD2;
    localparam int          BUS_LIMIT   = 20;
    localparam int          POLL_LIMIT  = 500;

    logic        clk = 1'b0;
    logic        i_arst_n;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [31:0] i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;
    logic        o_wb_err;
    logic        o_intr;

    int cycle_count = 0;
    int total_checks = 0;
    int fail_count = 0;
    int test_checks = 0;
    int test_fails = 0;
    bit aborted = 1'b0;

    sauria_subsystem dut (
        .i_system_clk (clk),
        .i_arst_n     (i_arst_n),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_wb_err     (o_wb_err),
        .o_intr       (o_intr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------
    // Checks and bus helpers
    // ------------------------------------------------------------
    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input logic [31:0] addr, input string what);
        total_checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s at address %h, got %h, expected %h",
                     $time, what, addr, got, exp);
            fail_count++;
            test_fails++;
        end
    endtask

    // One Wishbone classic cycle that starts and ends on a falling edge
    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdat, output logic got_ack,
                              output logic got_err, output logic [31:0] rdat);
        int waited;
        waited = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        rdat = '0;
        @(negedge clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = addr;
        i_wb_dat = wdat;
        while (!(got_ack || got_err) && waited < BUS_LIMIT) begin
            @(negedge clk);
            waited++;
            if (o_wb_ack || o_wb_err) begin
                got_ack = o_wb_ack;
                got_err = o_wb_err;
                rdat = o_wb_dat;
            end
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        if (!(got_ack || got_err)) begin
            $display("Timeout: no bus response for address %h after %0d cycles",
                     addr, BUS_LIMIT);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    // Read STATUS until the sticky done flag shows up
    task automatic poll_done();
        int          start_cycle;
        bit          found;
        logic        ack;
        logic        err;
        logic [31:0] rdat;
        start_cycle = cycle_count;
        found = 1'b0;
        while (!found && !aborted && (cycle_count - start_cycle) < POLL_LIMIT) begin
            bus_access(1'b0, STATUS_ADDR, 32'h0, ack, err, rdat);
            if (ack && rdat[1]) begin
                found = 1'b1;
            end
        end
        if (!found && !aborted) begin
            $display("Timeout: copy did not report done within %0d cycles", POLL_LIMIT);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int                fd;
        int                code;
        logic [8*16-1:0]   token;
        logic [8*256-1:0]  junk;
        logic [7:0]        op;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       we_flag;
        logic [31:0]       rdat;
        logic              ack;
        logic              err;

        i_arst_n = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        fd = $fopen("testbench/sauria_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file testbench/sauria_patterns.txt");
            fail_count++;
            aborted = 1'b1;
        end

        while (!aborted) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                break;
            end
            op = token[7:0];
            if (op == "#") begin
                code = $fgets(junk, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h", addr, data);
            case (op)
                "W": begin
                    bus_access(1'b1, addr, data, ack, err, rdat);
                    check_equal({30'b0, err, ack}, 32'd1, addr, "write response");
                end
                "R": begin
                    bus_access(1'b0, addr, 32'h0, ack, err, rdat);
                    check_equal({30'b0, err, ack}, 32'd1, addr, "read response");
                    check_equal(rdat, data, addr, "read data");
                end
                "E": begin
                    code = $fscanf(fd, "%h", we_flag);
                    bus_access(we_flag[0], addr, data, ack, err, rdat);
                    check_equal({30'b0, err, ack}, 32'd2, addr, "error response");
                    check_equal(rdat, ERR_WORD, addr, "error word");
                end
                "P": poll_done();
                "I": begin
                    @(negedge clk);
                    check_equal({31'b0, o_intr}, data, addr, "interrupt level");
                end
                "T": begin
                    $display("Test %0d finished: %0d checks, %0d failed",
                             addr, test_checks, test_fails);
                    test_checks = 0;
                    test_fails = 0;
                end
                default: begin
                    $display("Unknown operation %s in the pattern file", token);
                    fail_count++;
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (total_checks == 0 && !aborted) begin
            $display("No checks were run");
            fail_count++;
        end
        $display("Checks passed: %0d, failed: %0d", total_checks - fail_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/sauria_pkg.sv
verilog/cfg_bus_decoder.sv
verilog/ctrl_regfile.sv
verilog/df_control_fsm.sv
verilog/dma_word_counter.sv
verilog/scratch_mem.sv
verilog/sauria_subsystem.sv
testbench/tb_sauria_subsystem.sv

// ==== testbench/sauria_patterns.txt ====
# Columns: op addr data, hex. E lines add a fourth column, 1 write, 0 read
# Ops: W write, R read and compare, E expect err, P poll done, I compare o_intr, T end test
# Test 1: descriptor registers and an unused index
W 00000008 00000005
W 0000000C 00000028
W 00000010 00000050
W 00000018 12345678
R 00000008 00000005
R 0000000C 00000028
R 00000010 00000040
R 00000018 00000000
T 00000001 00000000
# Test 2: scratchpad debug access
W 00001000 11110000
W 00001004 22220001
W 00001010 A5A50004
W 000010FC 3F3F003F
R 00001000 11110000
R 00001004 22220001
R 00001010 A5A50004
R 000010FC 3F3F003F
T 00000002 00000000
# Test 3: unmapped addresses alias SRC, LEN and scratchpad word 4
E 00002008 00000000 0
E 00002008 DEADBEEF 1
E 0000F010 CAFEF00D 1
R 00000008 00000005
R 00000010 00000040
R 00001010 A5A50004
T 00000003 00000000
# Test 4: copy words 8 to 15 onto words 40 to 47
W 00001020 8A51C3E0
W 00001024 17F0A2B9
W 00001028 5C6D7E8F
W 0000102C E0011EE1
W 00001030 0000FFFF
W 00001034 FFFF0000
W 00001038 13572468
W 0000103C 9ABCDEF0
W 00000008 00000008
W 0000000C 00000028
W 00000010 00000008
W 00000000 00000001
P 00000000 00000000
R 000010A0 8A51C3E0
R 000010A4 17F0A2B9
R 000010A8 5C6D7E8F
R 000010AC E0011EE1
R 000010B0 0000FFFF
R 000010B4 FFFF0000
R 000010B8 13572468
R 000010BC 9ABCDEF0
R 00001020 8A51C3E0
R 00001024 17F0A2B9
R 00001028 5C6D7E8F
R 0000102C E0011EE1
R 00001030 0000FFFF
R 00001034 FFFF0000
R 00001038 13572468
R 0000103C 9ABCDEF0
T 00000004 00000000
# Test 5: interrupt enable, flag clear, and a zero-length copy
W 00000004 00000002
W 00000008 00000008
W 0000000C 00000030
W 00000010 00000002
W 00000000 00000003
R 00000000 00000002
P 00000000 00000000
I 00000000 00000001
W 00000004 00000002
I 00000000 00000000
R 00000004 00000000
W 00000000 00000001
P 00000000 00000000
I 00000000 00000000
W 00000004 00000002
W 00000008 00000004
W 0000000C 00000028
W 00000010 00000000
W 00000000 00000001
P 00000000 00000000
R 00000004 00000002
R 000010A0 8A51C3E0
R 000010C0 8A51C3E0
R 000010C4 17F0A2B9
T 00000005 00000000
